// ==== fm_ch_regs.sv ====
// channel settings store, one stage per channel
// fnum/block, fb/alg, pan/ams/pms
`timescale 1ns/100ps

module fm_ch_regs #(
    parameter int num_ch = 6
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               clk_en,
    input  fm_pkg::slot_t      cur_slot,
    input  fm_pkg::wr_req_t    req,
    output fm_pkg::ch_params_t ch
);

    fm_pkg::ch_params_t stage [num_ch];
    fm_pkg::ch_params_t upd;

    assign ch = stage[num_ch-1];

    // channel advances every slot, so each pass of a channel is one stage
    always_comb begin
        upd = stage[num_ch-1];
        if (req.slot.ch == cur_slot.ch) begin
            case (req.group)
                fm_pkg::ch_fnum: begin
                    upd.block = req.block;
                    upd.fnum  = {req.fnum_hi, req.data};
                end
                fm_pkg::ch_fb_alg: begin
                    upd.fb  = req.data.fb_alg.fb;
                    upd.alg = req.data.fb_alg.alg;
                end
                fm_pkg::ch_pan: begin
                    upd.rl  = (num_ch == 3) ? 2'b11 : req.data.pan.rl;  // no stereo
                    upd.ams = req.data.pan.ams;
                    upd.pms = req.data.pan.pms;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < num_ch; i++) begin
                stage[i]    <= '0;
                stage[i].rl <= 2'b11;   // both speakers on
            end
        end else if (clk_en) begin
            stage[0] <= upd;
            for (int i = 1; i < num_ch; i++)
                stage[i] <= stage[i-1];
        end
    end

endmodule

// ==== fm_keyon.sv ====
// key-on bit per slot, set from the 0x28 register
`timescale 1ns/100ps

module fm_keyon #(
    parameter int num_ch = 6
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            clk_en,
    input  fm_pkg::slot_t   cur_slot,
    input  fm_pkg::wr_req_t req,
    output logic            keyon
);

    localparam int n_slots = fm_pkg::slot_count(num_ch);

    logic [n_slots-1:0] kon_sr;
    logic [3:0]         mask;
    logic               upd;

    assign mask  = req.data.kon.mask;
    assign keyon = kon_sr[n_slots-1];

    // mask is s1,s2,s3,s4 but op codes run s1,s3,s2,s4: swap the code bits
    always_comb begin
        upd = kon_sr[n_slots-1];
        if (req.group == fm_pkg::keyon && req.slot.ch == cur_slot.ch)
            upd = mask[{cur_slot.op[0], cur_slot.op[1]}];
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            kon_sr <= '0;
        else if (clk_en)
            kon_sr <= {kon_sr[n_slots-2:0], upd};
    end

endmodule

// ==== fm_op_regs.sv ====
// operator settings store
// one shift stage per slot, rewritten as the target slot passes
`timescale 1ns/100ps

module fm_op_regs #(
    parameter int num_ch = 6
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               clk_en,
    input  fm_pkg::slot_t      cur_slot,
    input  fm_pkg::wr_req_t    req,
    output fm_pkg::op_params_t op
);

    localparam int n_slots = fm_pkg::slot_count(num_ch);

    fm_pkg::op_params_t stage [n_slots];
    fm_pkg::op_params_t upd;
    logic [7:0]         d;

    assign op = stage[n_slots-1];  // entry for cur_slot
    assign d  = req.data;

    always_comb begin
        upd = stage[n_slots-1];
        if (req.slot == cur_slot) begin
            case (req.group)
                fm_pkg::op_dt_mul: begin
                    upd.dt1 = d[6:4];
                    upd.mul = d[3:0];
                end
                fm_pkg::op_tl: upd.tl = d[6:0];
                fm_pkg::op_ks_ar: begin
                    upd.ks = d[7:6];
                    upd.ar = d[4:0];
                end
                fm_pkg::op_am_d1r: begin
                    upd.amen = d[7];
                    upd.d1r  = d[4:0];
                end
                fm_pkg::op_d2r: upd.d2r = d[4:0];
                fm_pkg::op_sl_rr: begin
                    upd.sl = d[7:4];
                    upd.rr = d[3:0];
                end
                fm_pkg::op_ssg: begin
                    upd.ssg_en = d[3];
                    upd.ssg_eg = d[2:0];
                end
                default: ;  // channel and key-on groups not stored here
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < n_slots; i++)
                stage[i] <= '0;
        end else if (clk_en) begin
            stage[0] <= upd;    // recirculate
            for (int i = 1; i < n_slots; i++)
                stage[i] <= stage[i-1];
        end
    end

endmodule

// ==== fm_pkg.sv ====
// shared types for the FM register block
// slot code, bus data views, write request, parameter words
package fm_pkg;

    // op code is processing order: 0=s1 1=s3 2=s2 3=s4
    typedef struct packed {
        logic [1:0] op;
        logic [2:0] ch;     // 0,1,2,4,5,6 in 6-channel mode
    } slot_t;

    typedef struct packed {
        logic [3:0] mask;   // bit 0=s1 1=s2 2=s3 3=s4
        logic       rsv;
        logic [2:0] ch;
    } kon_view_t;

    typedef struct packed {
        logic [1:0] rsv;
        logic [2:0] fb;
        logic [2:0] alg;
    } fb_alg_view_t;

    typedef struct packed {
        logic [1:0] rl;
        logic [1:0] ams;
        logic       rsv;
        logic [2:0] pms;
    } pan_view_t;

    // same data byte, read per target register
    typedef union packed {
        kon_view_t    kon;
        fb_alg_view_t fb_alg;
        pan_view_t    pan;
    } data_view_u;

    typedef enum logic [3:0] {
        op_dt_mul, op_tl, op_ks_ar, op_am_d1r, op_d2r, op_sl_rr, op_ssg,
        ch_fnum, ch_fb_alg, ch_pan,
        keyon, none
    } reg_group_e;

    typedef struct packed {
        reg_group_e group;
        slot_t      slot;
        data_view_u data;
        logic [2:0] block;      // latched from 0xA4
        logic [2:0] fnum_hi;
    } wr_req_t;

    typedef struct packed {
        logic [2:0] dt1;
        logic [3:0] mul;
        logic [6:0] tl;
        logic [1:0] ks;
        logic [4:0] ar;
        logic       amen;
        logic [4:0] d1r;
        logic [4:0] d2r;
        logic [3:0] sl;
        logic [3:0] rr;
        logic       ssg_en;
        logic [2:0] ssg_eg;
    } op_params_t;

    typedef struct packed {
        logic [2:0]  block;
        logic [10:0] fnum;
        logic [2:0]  fb;
        logic [2:0]  alg;
        logic [1:0]  rl;
        logic [1:0]  ams;
        logic [2:0]  pms;
    } ch_params_t;

    typedef struct packed {
        slot_t      slot;
        logic       first;
        logic       keyon;
        logic       carrier;
        op_params_t op;
        ch_params_t ch;
    } slot_params_t;

    function automatic int slot_count(int num_ch);
        return 4 * num_ch;
    endfunction

endpackage

// ==== fm_reg_properties.sv ====
// concurrent assertions for the FM register block
// slot sequence, reset state and busy timing; bound to the top
`timescale 1ns/100ps

module fm_reg_properties #(
    parameter int num_ch = 6
) (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 clk_en,
    input logic                 data_wr,
    input logic                 busy,
    input fm_pkg::slot_params_t params
);

    localparam int n_slots = fm_pkg::slot_count(num_ch);

    int   fails = 0;
    int   gap;          // enabled cycles since last first word
    logic seen_first;
    int   busy_len;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gap        <= 0;
            seen_first <= 1'b0;
        end else if (clk_en) begin
            if (params.first) begin
                gap        <= 1;
                seen_first <= 1'b1;
            end else begin
                gap <= gap + 1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || !busy)
            busy_len <= 0;
        else if (clk_en)
            busy_len <= busy_len + 1;
    end

    first_period: assert property (@(posedge clk) disable iff (!rst_n)
        clk_en && params.first && seen_first |-> gap == n_slots)
        else begin $error("first word came after %0d enabled cycles", gap); fails++; end

    first_not_late: assert property (@(posedge clk) disable iff (!rst_n)
        clk_en && seen_first |-> gap <= n_slots)
        else begin $error("first word missing in a round"); fails++; end

    no_unused_ch: assert property (@(posedge clk) disable iff (!rst_n)
        clk_en |-> params.slot.ch[1:0] != 2'd3)
        else begin $error("unused channel code in slot word"); fails++; end

    idle_after_reset: assert property (@(posedge clk)
        !rst_n |=> !busy && !params.first)
        else begin $error("busy or first high after reset"); fails++; end

    busy_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(busy) |-> $past(data_wr && clk_en))
        else begin $error("busy rose without a data write"); fails++; end

    busy_length: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy) |-> busy_len == n_slots)
        else begin $error("busy lasted %0d enabled cycles", busy_len); fails++; end

endmodule

bind fm_reg_top fm_reg_properties #(.num_ch(num_ch)) i_props (
    .clk(clk), .rst_n(rst_n), .clk_en(clk_en), .data_wr(data_wr),
    .busy(busy), .params(params)
);

// ==== fm_reg_top.sv ====
// register block top: decoder, sequencer, stores, output stage
`timescale 1ns/100ps

module fm_reg_top #(
    parameter int num_ch = 6
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 clk_en,
    input  logic                 addr_wr,
    input  logic                 data_wr,
    input  logic                 part,
    input  logic [7:0]           din,
    output logic                 busy,
    output fm_pkg::slot_params_t params
);

    fm_pkg::wr_req_t    req;
    fm_pkg::slot_t      cur_slot;
    logic               first;
    fm_pkg::op_params_t op;
    fm_pkg::ch_params_t ch;
    logic               keyon;

    fm_write_decode #(.num_ch(num_ch)) i_decode (
        .clk, .rst_n, .clk_en, .addr_wr, .data_wr, .part, .din,
        .req, .busy
    );

    fm_slot_counter #(.num_ch(num_ch)) i_slot_cnt (
        .clk, .rst_n, .clk_en, .cur_slot, .first
    );

    fm_op_regs #(.num_ch(num_ch)) i_op_regs (
        .clk, .rst_n, .clk_en, .cur_slot, .req, .op
    );

    fm_ch_regs #(.num_ch(num_ch)) i_ch_regs (
        .clk, .rst_n, .clk_en, .cur_slot, .req, .ch
    );

    fm_keyon #(.num_ch(num_ch)) i_keyon (
        .clk, .rst_n, .clk_en, .cur_slot, .req, .keyon
    );

    fm_slot_params i_out (
        .clk, .rst_n, .clk_en, .cur_slot, .first, .op, .ch, .keyon, .params
    );

endmodule

// ==== fm_slot_counter.sv ====
// slot sequencer in chip order, with first-slot flag
`timescale 1ns/100ps

module fm_slot_counter #(
    parameter int num_ch = 6
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          clk_en,
    output fm_pkg::slot_t cur_slot,
    output logic          first
);

    fm_pkg::slot_t next_slot;

    // channel codes skip 3 (and 7) in 6-channel mode
    always_comb begin
        next_slot = cur_slot;
        if (num_ch == 6) begin
            if (cur_slot.ch == 3'd6)
                next_slot.op = cur_slot.op + 2'd1;
            if (cur_slot.ch[1:0] == 2'd2)
                next_slot.ch = cur_slot.ch + 3'd2;  // 6 wraps to 0
            else
                next_slot.ch = cur_slot.ch + 3'd1;
        end else begin
            if (cur_slot.ch == 3'd2) begin
                next_slot.op = cur_slot.op + 2'd1;
                next_slot.ch = 3'd0;
            end else begin
                next_slot.ch = cur_slot.ch + 3'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            cur_slot <= '0;
        else if (clk_en)
            cur_slot <= next_slot;
    end

    assign first = (cur_slot.op == 2'd0) && (cur_slot.ch == 3'd0);  // s1 of ch 0

endmodule

// ==== fm_slot_params.sv ====
// output register for the slot word
// carrier flag decoded from algorithm and operator
`timescale 1ns/100ps

module fm_slot_params (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 clk_en,
    input  fm_pkg::slot_t        cur_slot,
    input  logic                 first,
    input  fm_pkg::op_params_t   op,
    input  fm_pkg::ch_params_t   ch,
    input  logic                 keyon,
    output fm_pkg::slot_params_t params
);

    logic carrier;

    // op codes: 0=s1 1=s3 2=s2 3=s4
    always_comb begin
        case (ch.alg)
            3'd4:       carrier = cur_slot.op[1];           // s2, s4
            3'd5, 3'd6: carrier = cur_slot.op != 2'd0;      // all but s1
            3'd7:       carrier = 1'b1;
            default:    carrier = cur_slot.op == 2'd3;      // s4 only
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            params       <= '0;
            params.ch.rl <= 2'b11;
        end else if (clk_en) begin
            params <= '{slot: cur_slot, first: first, keyon: keyon,
                        carrier: carrier, op: op, ch: ch};
        end
    end

endmodule

// ==== fm_write_decode.sv ====
// bus decoder: address latch, register group decode,
// block/fnum high latch and the one-round write request
`timescale 1ns/100ps

module fm_write_decode #(
    parameter int num_ch = 6
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              clk_en,
    input  logic              addr_wr,
    input  logic              data_wr,
    input  logic              part,
    input  logic [7:0]        din,
    output fm_pkg::wr_req_t   req,
    output logic              busy
);

    localparam int n_slots = fm_pkg::slot_count(num_ch);
    localparam int cnt_w   = $clog2(n_slots);

    logic [7:0]         addr_q;
    logic [2:0]         block_latch;
    logic [2:0]         fnum_hi_latch;
    logic [cnt_w-1:0]   cnt;
    fm_pkg::data_view_u din_v;
    fm_pkg::reg_group_e dec_group;
    fm_pkg::slot_t      dec_slot;
    logic [2:0]         ch_code;
    logic               ch_ok;
    logic               is_latch;

    assign din_v    = din;
    assign ch_code  = {part, addr_q[1:0]};
    assign ch_ok    = (addr_q[1:0] != 2'd3) && (num_ch == 6 || !part);
    assign is_latch = (addr_q[7:2] == 6'b1010_01) && ch_ok;    // 0xA4-0xA6

    always_comb begin
        dec_group = fm_pkg::none;
        dec_slot  = '{op: addr_q[3:2], ch: ch_code};
        if (addr_q == 8'h28) begin
            dec_slot = '{op: 2'd0, ch: din_v.kon.ch};
            if (din_v.kon.ch[1:0] != 2'd3
                    && (num_ch == 6 || (!din_v.kon.ch[2] && !part)))
                dec_group = fm_pkg::keyon;
        end else if (ch_ok) begin
            case (addr_q[7:4])
                4'h3: dec_group = fm_pkg::op_dt_mul;
                4'h4: dec_group = fm_pkg::op_tl;
                4'h5: dec_group = fm_pkg::op_ks_ar;
                4'h6: dec_group = fm_pkg::op_am_d1r;
                4'h7: dec_group = fm_pkg::op_d2r;
                4'h8: dec_group = fm_pkg::op_sl_rr;
                4'h9: dec_group = fm_pkg::op_ssg;
                4'ha: if (addr_q[3:2] == 2'd0) dec_group = fm_pkg::ch_fnum;
                4'hb: begin
                    if (addr_q[3:2] == 2'd0)
                        dec_group = fm_pkg::ch_fb_alg;
                    else if (addr_q[3:2] == 2'd1)
                        dec_group = fm_pkg::ch_pan;
                end
                default: dec_group = fm_pkg::none;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            addr_q        <= '0;
            block_latch   <= '0;
            fnum_hi_latch <= '0;
            busy          <= 1'b0;
            cnt           <= '0;
            req           <= '0;
            req.group     <= fm_pkg::none;
        end else if (clk_en) begin
            if (addr_wr)
                addr_q <= din;
            if (busy) begin
                if (cnt == '0) begin
                    busy      <= 1'b0;
                    req.group <= fm_pkg::none;  // round done
                end else begin
                    cnt <= cnt - 1'b1;
                end
            end else if (data_wr) begin     // writes during busy are lost
                if (is_latch) begin
                    block_latch   <= din[5:3];
                    fnum_hi_latch <= din[2:0];
                end
                if (dec_group != fm_pkg::none) begin
                    busy <= 1'b1;
                    cnt  <= cnt_w'(n_slots - 1);
                    req  <= '{group: dec_group, slot: dec_slot, data: din_v,
                              block: block_latch, fnum_hi: fnum_hi_latch};
                end
            end
        end
    end

endmodule

// ==== list.f ====
fm_pkg.sv
fm_write_decode.sv
fm_slot_counter.sv
fm_op_regs.sv
fm_ch_regs.sv
fm_keyon.sv
fm_slot_params.sv
fm_reg_top.sv
fm_reg_properties.sv
tb_fm_reg.sv

// ==== run.sh ====
#!/bin/sh
# build and run the FM register block testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_fm_reg -f list.f -o tb_fm_reg
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/tb_fm_reg +verilator+error+limit+1000 > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "Result: PASSED" "$LOG"; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0

// ==== tb_fm_reg.sv ====
// testbench for the FM register block
// clock, reset, bus writes, model of written values and checks on every params word
`timescale 1ns/100ps

module tb_fm_reg;

    localparam int num_ch  = 6;
    localparam int n_slots = 4 * num_ch;   // slots per round

    logic                 clk;
    logic                 rst_n;
    logic                 clk_en;
    logic                 addr_wr;
    logic                 data_wr;
    logic                 part;
    logic [7:0]           din;
    logic                 busy;
    fm_pkg::slot_params_t params;

    fm_pkg::op_params_t model_op [32];     // indexed by slot code
    fm_pkg::ch_params_t model_ch [8];      // indexed by channel code
    logic               model_kon [32];
    logic [5:0]         fhi_latch;         // block, fnum high
    logic [2:0]         ch_list [6] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5, 3'd6};
    int                 seed;
    int                 errors;
    int                 checks;
    int                 timeouts;
    int                 slot_pos;          // round position of the word being checked
    string              test_name;
    logic               check_on;
    logic               busy_q;

    fm_reg_top #(.num_ch(num_ch)) i_dut (
        .clk(clk), .rst_n(rst_n), .clk_en(clk_en), .addr_wr(addr_wr),
        .data_wr(data_wr), .part(part), .din(din), .busy(busy), .params(params)
    );

    always #10 clk = ~clk;
    always @(posedge clk) clk_en <= ~clk_en;   // every other cycle

    function automatic logic [2:0] pick_ch();
        int idx;
        idx = $unsigned($random(seed)) % 6;
        return ch_list[idx];
    endfunction

    // carrier table, op codes 0=s1 1=s3 2=s2 3=s4
    function automatic logic carrier_of(input logic [2:0] alg, input logic [1:0] op);
        case (alg)
            3'd4:       return op == 2'd2 || op == 2'd3;
            3'd5, 3'd6: return op != 2'd0;
            3'd7:       return 1'b1;
            default:    return op == 2'd3;
        endcase
    endfunction

    task automatic log_mismatch(input string what, input logic [63:0] exp, input logic [63:0] act);
        errors++;
        $display("error %s %s: expected %h, actual %h", test_name, what, exp, act);
    endtask

    task automatic note_timeout(input string what);
        timeouts++;
        $display("timeout: %s did not happen in time", what);
    endtask

    // chip order: op code steps once per pass over the channel list
    task automatic check_slot();
        fm_pkg::slot_t exp_slot;
        logic          exp_first;
        exp_slot.op = 2'(slot_pos / num_ch);
        exp_slot.ch = ch_list[slot_pos % num_ch];
        exp_first   = (slot_pos == 0);
        assert (params.slot == exp_slot)
            else log_mismatch("slot", 64'(exp_slot), 64'(params.slot));
        assert (params.first == exp_first)
            else log_mismatch("first", 64'(exp_first), 64'(params.first));
    endtask

    task automatic check_word();
        logic [4:0] si;
        logic [2:0] c;
        si = params.slot;
        c  = params.slot.ch;
        checks++;
        assert (params.op == model_op[si])
            else log_mismatch("op params", 64'(model_op[si]), 64'(params.op));
        assert (params.ch == model_ch[c])
            else log_mismatch("ch params", 64'(model_ch[c]), 64'(params.ch));
        assert (params.keyon == model_kon[si])
            else log_mismatch("keyon", 64'(model_kon[si]), 64'(params.keyon));
        assert (params.carrier == carrier_of(model_ch[c].alg, params.slot.op))
            else log_mismatch("carrier", 64'(carrier_of(model_ch[c].alg, params.slot.op)),
                              64'(params.carrier));
    endtask

    // a new word shows at the negedge after each enabled edge;
    // skip words of a write round and the one leaving with it
    always @(negedge clk) begin
        if (check_on && !clk_en) begin
            if (slot_pos >= 0)
                check_slot();
            slot_pos = (slot_pos + 1) % n_slots;
            if (!busy && !busy_q)
                check_word();
            busy_q = busy;
        end
    end

    // returns on a posedge whose following cycle is enabled
    task automatic align_phase();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (clk_en && n < 4);
        if (clk_en)
            note_timeout("clock enable phase");
    endtask

    task automatic bus_write(input logic [7:0] a, input logic [7:0] d, input logic p);
        align_phase();
        addr_wr <= 1'b1;
        din     <= a;
        part    <= p;
        @(posedge clk);     // address sampled
        addr_wr <= 1'b0;
        @(posedge clk);
        data_wr <= 1'b1;
        din     <= d;
        @(posedge clk);     // data sampled
        data_wr <= 1'b0;
    endtask

    task automatic wait_idle(output int en_cycles);
        int n;
        en_cycles = 0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (busy && clk_en)
                en_cycles++;
        end while (busy && n < 200);
        if (busy)
            note_timeout("busy to fall");
    endtask

    task automatic wait_words(input int num);
        int cnt;
        int guard;
        cnt   = 0;
        guard = 0;
        while (cnt < num && guard < 4 * num) begin
            @(posedge clk);
            guard++;
            if (clk_en)
                cnt++;
        end
        if (cnt < num)
            note_timeout("params words");
    endtask

    // register layout of the chip, applied to the model
    task automatic apply_model(input logic [7:0] a, input logic [7:0] d, input logic p);
        logic [2:0] c;
        logic [4:0] si;
        c  = {p, a[1:0]};
        si = {a[3:2], c};
        if (a == 8'h28) begin
            model_kon[{2'd0, d[2:0]}] = d[4];  // s1
            model_kon[{2'd2, d[2:0]}] = d[5];  // s2
            model_kon[{2'd1, d[2:0]}] = d[6];  // s3
            model_kon[{2'd3, d[2:0]}] = d[7];  // s4
        end else begin
            case (a[7:4])
                4'h3: begin
                    model_op[si].dt1 = d[6:4];
                    model_op[si].mul = d[3:0];
                end
                4'h4: model_op[si].tl = d[6:0];
                4'h5: begin
                    model_op[si].ks = d[7:6];
                    model_op[si].ar = d[4:0];
                end
                4'ha: begin
                    if (a[2]) begin
                        fhi_latch = d[5:0];
                    end else begin
                        model_ch[c].block = fhi_latch[5:3];
                        model_ch[c].fnum  = {fhi_latch[2:0], d};
                    end
                end
                4'hb: begin
                    if (a[2]) begin
                        model_ch[c].rl  = d[7:6];
                        model_ch[c].ams = d[5:4];
                        model_ch[c].pms = d[2:0];
                    end else begin
                        model_ch[c].fb  = d[5:3];
                        model_ch[c].alg = d[2:0];
                    end
                end
                default: ;
            endcase
        end
    endtask

    task automatic write_reg(input logic [7:0] a, input logic [7:0] d, input logic p,
                             input logic round);
        int n;
        bus_write(a, d, p);
        apply_model(a, d, p);
        if (round) begin
            wait_idle(n);
            assert (n == n_slots)
                else log_mismatch("busy length", 64'(n_slots), 64'(n));
            wait_words(n_slots + 2);
        end
    endtask

    initial begin
        int         n;
        logic [2:0] c;
        logic [1:0] o;
        logic [3:0] nib;
        logic [7:0] a;
        seed      = 7374;
        clk       = 1'b0;
        rst_n     = 1'b0;
        clk_en    = 1'b0;
        addr_wr   = 1'b0;
        data_wr   = 1'b0;
        part      = 1'b0;
        din       = 8'h00;
        errors    = 0;
        checks    = 0;
        timeouts  = 0;
        slot_pos  = -1;     // first checked word is still the reset value
        check_on  = 1'b0;
        busy_q    = 1'b0;
        fhi_latch = '0;
        test_name = "reset";
        for (int i = 0; i < 32; i++) begin
            model_op[i]  = '0;
            model_kon[i] = 1'b0;
        end
        for (int i = 0; i < 8; i++) begin
            model_ch[i]    = '0;
            model_ch[i].rl = 2'b11;
        end
        repeat (2) @(posedge clk);
        rst_n    <= 1'b1;
        check_on <= 1'b1;
        wait_words(n_slots + 2);

        test_name = "op_write";
        for (int i = 0; i < 9; i++) begin
            c   = pick_ch();
            o   = 2'($random(seed));
            nib = 4'h3 + 4'(i % 3);    // dt/mul, tl, ks/ar
            write_reg({nib, o, c[1:0]}, 8'($random(seed)), c[2], 1'b1);
        end

        test_name = "ch_freq";
        repeat (3) begin
            c = pick_ch();
            write_reg({6'b1010_01, c[1:0]}, 8'($random(seed)), c[2], 1'b0);
            write_reg({6'b1010_00, c[1:0]}, 8'($random(seed)), c[2], 1'b1);
        end
        c = pick_ch();
        write_reg({6'b1010_01, c[1:0]}, 8'($random(seed)), c[2], 1'b0);  // latch only
        wait_words(n_slots + 2);
        write_reg({6'b1011_01, c[1:0]}, 8'($random(seed)), c[2], 1'b1);  // pan, ams, pms

        test_name = "carrier";
        c = pick_ch();
        for (int alg = 0; alg < 8; alg++)
            write_reg({6'b1011_00, c[1:0]}, {2'b00, 3'($random(seed)), 3'(alg)}, c[2], 1'b1);

        test_name = "keyon";
        repeat (6) begin
            c = pick_ch();
            write_reg(8'h28, {4'($random(seed)), 1'b0, c}, 1'b0, 1'b1);
        end

        test_name = "busy_drop";
        c = pick_ch();
        o = 2'($random(seed));
        a = {4'h4, o, c[1:0]};
        write_reg(a, 8'($random(seed)), c[2], 1'b0);
        bus_write(a, 8'($random(seed)), c[2]);    // lands during busy
        wait_idle(n);
        wait_words(n_slots + 2);

        $display("checks %0d, errors %0d, property failures %0d, timeouts %0d",
                 checks, errors, i_dut.i_props.fails, timeouts);
        if (errors == 0 && i_dut.i_props.fails == 0 && timeouts == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule
